// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= cache_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing --timescale 1ns/1ps -j 0
LINTFLAGS ?= --lint-only --assert --timing --timescale 1ns/1ps
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= All tests passed!

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# The log decides pass or fail
run: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/cache_consts.svh ====
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// Data cache geometry
`define DCACHE_BITS 1024
`define DCACHE_BLOCK_WORDS 2
`define DCACHE_WAYS 2

// Instruction cache, one word per frame
`define ICACHE_FRAMES 16

// Backing RAM, 4 KB of words
`define RAM_WORDS 1024
// Busy cycles before an access completes
`define RAM_LATENCY 2
// Word at byte address a starts as a ^ key
`define RAM_INIT_KEY 32'hA5A5_0000

`endif

// ==== common/cpu_types_pkg.sv ====
`include "cache_consts.svh"

package cpu_types_pkg;

  typedef logic [31:0] word_t;

  // Data cache organization
  localparam int DC_FRAMES = `DCACHE_BITS / (32 * `DCACHE_BLOCK_WORDS);
  localparam int DC_SETS = DC_FRAMES / `DCACHE_WAYS;
  localparam int DC_IDX_W = $clog2(DC_SETS);
  localparam int DC_BLK_W = $clog2(`DCACHE_BLOCK_WORDS);
  localparam int DC_TAG_W = 32 - DC_IDX_W - DC_BLK_W - 2;

  // Same address word, whole or split into lookup fields
  typedef union packed {
    word_t raw;
    struct packed {
      logic [DC_TAG_W-1:0] tag;
      logic [DC_IDX_W-1:0] idx;
      logic [DC_BLK_W-1:0] blkoff;
      logic [1:0]          bytoff;
    } fields;
  } dcache_addr_t;

  // One way of one set
  typedef struct packed {
    logic                            valid;
    logic                            dirty;
    logic [DC_TAG_W-1:0]             tag;
    word_t [`DCACHE_BLOCK_WORDS-1:0] data;
  } dcache_frame_t;

endpackage

// ==== common/mem_bus_pkg.sv ====
package mem_bus_pkg;

  // Current owner of the shared RAM port
  typedef enum logic [1:0] {
    GRANT_NONE,
    GRANT_D,
    GRANT_I
  } arb_grant_t;

  // RAM access progress
  typedef enum logic [1:0] {
    RAM_IDLE,
    RAM_BUSY,
    RAM_DONE
  } ram_state_t;

endpackage

// ==== compile.f ====
+incdir+common
common/cpu_types_pkg.sv
common/mem_bus_pkg.sv
dcache/dcache.sv
source/icache.sv
source/memory_arbiter.sv
source/ram_model.sv
source/memory_subsystem.sv
sim/dcache_props.sv
sim/cache_tb.sv

// ==== dcache/dcache.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module dcache
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  halt,
  input  word_t d_load,
  input  logic  d_wait,
  output word_t dmem_load,
  output logic  dhit,
  output logic  flushed,
  output logic  d_ren,
  output logic  d_wen,
  output word_t d_addr,
  output word_t d_store
);

  localparam int FCNT_W = $clog2(DC_FRAMES) + 1;

  typedef enum logic [3:0] {
    IDLE, WB0, WB1, LOAD0, LOAD1, FLUSH, FWB0, FWB1, FLUSHED
  } state_t;

  state_t state, next_state;
  dcache_frame_t frames [DC_SETS][`DCACHE_WAYS];
  dcache_frame_t next_frames [DC_SETS][`DCACHE_WAYS];
  logic [DC_SETS-1:0] lru, next_lru;
  logic [FCNT_W-1:0] flush_cnt, next_flush_cnt;
  logic victim, next_victim;
  dcache_addr_t req, mem_addr;
  logic [DC_IDX_W-1:0] idx;
  logic req_any, hit0, hit1;
  logic flush_way;
  logic [DC_IDX_W-1:0] flush_idx;

  assign req.raw = dmem_addr;
  assign idx = req.fields.idx;
  assign req_any = dmem_ren | dmem_wen;
  assign hit0 = frames[idx][0].valid && (frames[idx][0].tag == req.fields.tag);
  assign hit1 = frames[idx][1].valid && (frames[idx][1].tag == req.fields.tag);

  // Flush walks way 0 of all sets, then way 1
  assign flush_way = flush_cnt[DC_IDX_W];
  assign flush_idx = flush_cnt[DC_IDX_W-1:0];

  assign d_addr = mem_addr.raw;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= IDLE;
      frames <= '{default: '0};
      lru <= '0;
      flush_cnt <= '0;
      victim <= 1'b0;
    end else begin
      state <= next_state;
      frames <= next_frames;
      lru <= next_lru;
      flush_cnt <= next_flush_cnt;
      victim <= next_victim;
    end
  end

  always_comb begin
    next_state = state;
    next_frames = frames;
    next_lru = lru;
    next_flush_cnt = flush_cnt;
    next_victim = victim;
    dhit = 1'b0;
    dmem_load = '0;
    flushed = 1'b0;
    d_ren = 1'b0;
    d_wen = 1'b0;
    d_store = '0;
    mem_addr.raw = '0;

    case (state)
      IDLE: begin
        if (halt) begin
          next_state = FLUSH;
          next_flush_cnt = '0;
        end else if (req_any && (hit0 || hit1)) begin
          dhit = 1'b1;
          // Other way becomes the next victim
          next_lru[idx] = hit0;
          if (dmem_wen) begin
            next_frames[idx][hit1].data[req.fields.blkoff] = dmem_store;
            next_frames[idx][hit1].dirty = 1'b1;
          end else begin
            dmem_load = frames[idx][hit1].data[req.fields.blkoff];
          end
        end else if (req_any) begin
          // Empty way first, else LRU
          if (!frames[idx][0].valid) begin
            next_victim = 1'b0;
          end else if (!frames[idx][1].valid) begin
            next_victim = 1'b1;
          end else begin
            next_victim = lru[idx];
          end
          next_state = frames[idx][next_victim].dirty ? WB0 : LOAD0;
        end
      end

      WB0, WB1: begin
        d_wen = 1'b1;
        mem_addr.fields.tag = frames[idx][victim].tag;
        mem_addr.fields.idx = idx;
        mem_addr.fields.blkoff = (state == WB1);
        d_store = frames[idx][victim].data[state == WB1];
        if (!d_wait) begin
          next_state = (state == WB0) ? WB1 : LOAD0;
        end
      end

      LOAD0, LOAD1: begin
        d_ren = 1'b1;
        mem_addr.fields.tag = req.fields.tag;
        mem_addr.fields.idx = idx;
        mem_addr.fields.blkoff = (state == LOAD1);
        if (!d_wait) begin
          next_frames[idx][victim].data[state == LOAD1] = d_load;
          if (state == LOAD0) begin
            // Old block is gone once its first word is overwritten
            next_frames[idx][victim].valid = 1'b0;
            next_frames[idx][victim].dirty = 1'b0;
            next_state = LOAD1;
          end else begin
            next_frames[idx][victim].tag = req.fields.tag;
            next_frames[idx][victim].valid = 1'b1;
            next_state = IDLE;
          end
        end
      end

      FLUSH: begin
        if (flush_cnt == FCNT_W'(DC_FRAMES)) begin
          next_state = FLUSHED;
        end else if (frames[flush_idx][flush_way].dirty) begin
          next_state = FWB0;
        end else begin
          next_frames[flush_idx][flush_way].valid = 1'b0;
          next_flush_cnt = flush_cnt + 1'b1;
        end
      end

      FWB0, FWB1: begin
        d_wen = 1'b1;
        mem_addr.fields.tag = frames[flush_idx][flush_way].tag;
        mem_addr.fields.idx = flush_idx;
        mem_addr.fields.blkoff = (state == FWB1);
        d_store = frames[flush_idx][flush_way].data[state == FWB1];
        if (!d_wait) begin
          if (state == FWB0) begin
            next_state = FWB1;
          end else begin
            next_frames[flush_idx][flush_way].valid = 1'b0;
            next_frames[flush_idx][flush_way].dirty = 1'b0;
            next_flush_cnt = flush_cnt + 1'b1;
            next_state = FLUSH;
          end
        end
      end

      FLUSHED: begin
        flushed = 1'b1;
        if (!halt) begin
          next_state = IDLE;
        end
      end

      default: next_state = IDLE;
    endcase
  end

endmodule

// ==== sim/cache_tb.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_tb
  import cpu_types_pkg::*;
();

  localparam int TIMEOUT_CYCLES = 20000;

  logic  CLK, nRST;
  logic  dmem_ren, dmem_wen, halt, imem_ren;
  word_t dmem_addr, dmem_store, imem_addr;
  word_t dmem_load, imem_load;
  logic  dhit, flushed, ihit;

  string test_name;
  // Words stored so far, keyed by word-aligned byte address
  word_t shadow [word_t];
  word_t flush_addrs [$];
  int    cycles = 0;

  memory_subsystem dut_i (.*);

  always #10 CLK = ~CLK;

  function automatic word_t ref_load(input word_t addr);
    word_t a;
    a = {addr[31:2], 2'b00};
    if (shadow.exists(a)) begin
      return shadow[a];
    end else begin
      return a ^ `RAM_INIT_KEY;
    end
  endfunction

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input word_t exp, input word_t act);
    if (exp !== act) begin
      $display("FAILED %s: expected %h, actual %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  task automatic check_quiet();
    check_value("quiet dhit", 32'd0, word_t'(dhit));
    check_value("quiet ihit", 32'd0, word_t'(ihit));
    check_value("quiet flushed", 32'd0, word_t'(flushed));
  endtask

  // Hold one data request until dhit, return the stall cycles
  task automatic data_access(input logic wr, input word_t addr, input word_t val,
                             output int waits);
    @(negedge CLK);
    dmem_ren = !wr;
    dmem_wen = wr;
    dmem_addr = addr;
    dmem_store = val;
    waits = 0;
    @(posedge CLK);
    while (!dhit) begin
      waits++;
      @(posedge CLK);
    end
    if (wr) begin
      shadow[{addr[31:2], 2'b00}] = val;
    end
    @(negedge CLK);
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
  endtask

  task automatic fetch(input word_t addr);
    @(negedge CLK);
    imem_ren = 1'b1;
    imem_addr = addr;
    @(posedge CLK);
    while (!ihit) @(posedge CLK);
    @(negedge CLK);
    imem_ren = 1'b0;
  endtask

  // Compare every completed load and fetch with the shadow
  always @(posedge CLK) begin
    if (nRST && dhit && dmem_ren) begin
      check_value(test_name, ref_load(dmem_addr), dmem_load);
    end
    if (nRST && ihit) begin
      check_value("instruction fetch", ref_load(imem_addr), imem_load);
    end
    if (dut_i.dcache_i.props_i.fail_count != 0) begin
      $display("ERROR: a data cache assertion failed");
      stop_with_failure();
    end
  end

  always @(posedge CLK) begin
    cycles++;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("ERROR: run exceeded %0d cycles, a request or the flush never finished",
               TIMEOUT_CYCLES);
      stop_with_failure();
    end
  end

  initial begin : main
    int waits;
    int k;
    word_t addr;
    word_t val;
    dcache_addr_t conf;
    word_t conf_addrs [8];
    CLK = 1'b0;
    nRST = 1'b0;
    dmem_ren = 1'b0;
    dmem_wen = 1'b0;
    dmem_addr = '0;
    dmem_store = '0;
    halt = 1'b0;
    imem_ren = 1'b0;
    imem_addr = '0;
    void'($urandom(32'h4650));

    test_name = "reset";
    repeat (4) begin
      @(negedge CLK);
      check_quiet();
    end
    nRST = 1'b1;
    repeat (2) begin
      @(posedge CLK);
      check_quiet();
    end

    // One block per set, so the second word always hits
    test_name = "read miss then hit";
    for (int i = 0; i < 8; i++) begin
      addr = word_t'(32'h100 + i * 8);
      data_access(1'b0, addr, '0, waits);
      data_access(1'b0, addr + 4, '0, waits);
      check_value("read hit latency", 32'd0, word_t'(waits));
    end

    test_name = "store then load";
    for (int i = 0; i < 8; i++) begin
      addr = word_t'(32'h200 + i * 4);
      val = $urandom;
      data_access(1'b1, addr, val, waits);
      data_access(1'b0, addr, '0, waits);
      data_access(1'b0, addr ^ 32'h4, '0, waits);
    end

    // Four tags on set 5 force dirty evictions
    test_name = "eviction write-back";
    for (int i = 0; i < 8; i++) begin
      conf.raw = '0;
      conf.fields.tag = DC_TAG_W'(i / 2 + 1);
      conf.fields.idx = DC_IDX_W'(5);
      conf.fields.blkoff = DC_BLK_W'(i % 2);
      conf_addrs[i] = conf.raw;
      data_access(1'b1, conf.raw, $urandom, waits);
    end
    for (int i = 0; i < 40; i++) begin
      k = int'($urandom % 8);
      if ($urandom % 3 == 0) begin
        data_access(1'b1, conf_addrs[k], $urandom, waits);
      end else begin
        data_access(1'b0, conf_addrs[k], '0, waits);
      end
    end

    test_name = "halt flush";
    for (int i = 0; i < 8; i++) begin
      addr = word_t'((i * 32 + int'($urandom % 32)) * 8);
      flush_addrs.push_back(addr);
      data_access(1'b1, addr, $urandom, waits);
    end
    @(negedge CLK);
    halt = 1'b1;
    @(posedge CLK);
    while (!flushed) @(posedge CLK);
    repeat (5) begin
      @(posedge CLK);
      check_value("flushed held", 32'd1, word_t'(flushed));
    end
    @(negedge CLK);
    halt = 1'b0;
    foreach (flush_addrs[i]) begin
      data_access(1'b0, flush_addrs[i], '0, waits);
      check_value("reload after flush misses", 32'd1, word_t'(waits != 0));
    end

    // Fetches stay above 0x800, data traffic below
    test_name = "data under fetch contention";
    fork
      begin
        for (int i = 0; i < 30; i++) begin
          addr = word_t'(($urandom % 512) * 4);
          if ($urandom % 4 == 0) begin
            data_access(1'b1, addr, $urandom, waits);
          end else begin
            data_access(1'b0, addr, '0, waits);
          end
        end
      end
      begin
        for (int i = 0; i < 40; i++) begin
          fetch(word_t'(32'h800 + ($urandom % 64) * 4));
        end
      end
    join

    @(posedge CLK);
    if (dut_i.dcache_i.props_i.fail_count == 0) begin
      $display("All tests passed!");
      $finish;
    end else begin
      $display("ERROR: data cache assertions failed");
      stop_with_failure();
    end
  end

endmodule

// ==== sim/dcache_props.sv ====
`timescale 1ns/1ps

module dcache_props
  import cpu_types_pkg::*;
(
  input logic  CLK,
  input logic  nRST,
  input logic  dmem_ren,
  input logic  dmem_wen,
  input logic  dhit,
  input logic  flushed,
  input logic  d_ren,
  input logic  d_wen,
  input logic  d_wait,
  input word_t d_addr,
  input word_t d_store
);

  int fail_count = 0;

  // Read and write never requested together
  assert property (@(posedge CLK) disable iff (!nRST) !(d_ren && d_wen))
    else begin
      fail_count++;
      $error("d_ren and d_wen high in the same cycle");
    end

  assert property (@(posedge CLK) disable iff (!nRST) dhit |-> (dmem_ren || dmem_wen))
    else begin
      fail_count++;
      $error("dhit high with no CPU request");
    end

  // Address and store data held while the memory side stalls
  assert property (@(posedge CLK) disable iff (!nRST)
      (d_ren || d_wen) && d_wait |=> $stable(d_addr) && $stable(d_store))
    else begin
      fail_count++;
      $error("d_addr or d_store changed while d_wait was high");
    end

  assert property (@(posedge CLK) disable iff (!nRST) flushed |-> !(d_ren || d_wen))
    else begin
      fail_count++;
      $error("memory request while flushed is high");
    end

endmodule

bind dcache dcache_props props_i (
  .CLK, .nRST, .dmem_ren, .dmem_wen, .dhit, .flushed,
  .d_ren, .d_wen, .d_wait, .d_addr, .d_store
);

// ==== source/icache.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module icache
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  imem_ren,
  input  word_t imem_addr,
  input  word_t i_load,
  input  logic  i_wait,
  output word_t imem_load,
  output logic  ihit,
  output logic  i_ren,
  output word_t i_addr
);

  localparam int IDX_W = $clog2(`ICACHE_FRAMES);
  localparam int TAG_W = 30 - IDX_W;

  logic [`ICACHE_FRAMES-1:0] valid;
  logic [TAG_W-1:0] tags [`ICACHE_FRAMES];
  word_t data [`ICACHE_FRAMES];
  logic [IDX_W-1:0] idx;
  logic [TAG_W-1:0] tag;
  logic fill;

  // Word address split, byte offset ignored
  assign idx = imem_addr[IDX_W+1:2];
  assign tag = imem_addr[31:IDX_W+2];

  assign ihit = imem_ren && valid[idx] && (tags[idx] == tag);
  assign imem_load = ihit ? data[idx] : '0;

  // Miss goes straight out and stays up until the word arrives
  assign i_ren = imem_ren && !ihit;
  assign i_addr = {imem_addr[31:2], 2'b00};
  assign fill = i_ren && !i_wait;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      valid <= '0;
    end else if (fill) begin
      valid[idx] <= 1'b1;
    end
  end

  always_ff @(posedge CLK) begin
    if (fill) begin
      tags[idx] <= tag;
      data[idx] <= i_load;
    end
  end

endmodule

// ==== source/memory_arbiter.sv ====
`timescale 1ns/1ps

module memory_arbiter
  import cpu_types_pkg::*;
  import mem_bus_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  d_ren,
  input  logic  d_wen,
  input  word_t d_addr,
  input  word_t d_store,
  input  logic  i_ren,
  input  word_t i_addr,
  input  word_t ram_load,
  input  logic  ram_wait,
  output word_t d_load,
  output logic  d_wait,
  output word_t i_load,
  output logic  i_wait,
  output logic  ram_ren,
  output logic  ram_wen,
  output word_t ram_addr,
  output word_t ram_store
);

  arb_grant_t grant, owner;

  // A locked grant wins, otherwise data side first
  always_comb begin
    if (grant != GRANT_NONE) begin
      owner = grant;
    end else if (d_ren || d_wen) begin
      owner = GRANT_D;
    end else if (i_ren) begin
      owner = GRANT_I;
    end else begin
      owner = GRANT_NONE;
    end
  end

  // Released in the cycle the owner's access completes
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      grant <= GRANT_NONE;
    end else if (owner != GRANT_NONE && !ram_wait) begin
      grant <= GRANT_NONE;
    end else begin
      grant <= owner;
    end
  end

  always_comb begin
    ram_ren = 1'b0;
    ram_wen = 1'b0;
    ram_addr = '0;
    ram_store = '0;
    case (owner)
      GRANT_D: begin
        ram_ren = d_ren;
        ram_wen = d_wen;
        ram_addr = d_addr;
        ram_store = d_store;
      end
      GRANT_I: begin
        ram_ren = i_ren;
        ram_addr = i_addr;
      end
      default: ;
    endcase
  end

  assign d_wait = (owner == GRANT_D) ? ram_wait : 1'b1;
  assign i_wait = (owner == GRANT_I) ? ram_wait : 1'b1;
  assign d_load = ram_load;
  assign i_load = ram_load;

endmodule

// ==== source/memory_subsystem.sv ====
`timescale 1ns/1ps

module memory_subsystem
  import cpu_types_pkg::*;
(
  input  logic  CLK,
  input  logic  nRST,
  input  logic  dmem_ren,
  input  logic  dmem_wen,
  input  word_t dmem_addr,
  input  word_t dmem_store,
  input  logic  halt,
  output word_t dmem_load,
  output logic  dhit,
  output logic  flushed,
  input  logic  imem_ren,
  input  word_t imem_addr,
  output word_t imem_load,
  output logic  ihit
);

  // Cache side of the arbiter
  logic  d_ren, d_wen, d_wait, i_ren, i_wait;
  word_t d_addr, d_store, d_load, i_addr, i_load;
  // RAM side
  logic  ram_ren, ram_wen, ram_wait;
  word_t ram_addr, ram_store, ram_load;

  dcache dcache_i (
    .CLK, .nRST,
    .dmem_ren, .dmem_wen, .dmem_addr, .dmem_store, .halt,
    .d_load, .d_wait,
    .dmem_load, .dhit, .flushed,
    .d_ren, .d_wen, .d_addr, .d_store
  );

  icache icache_i (
    .CLK, .nRST,
    .imem_ren, .imem_addr, .i_load, .i_wait,
    .imem_load, .ihit, .i_ren, .i_addr
  );

  memory_arbiter arbiter_i (
    .CLK, .nRST,
    .d_ren, .d_wen, .d_addr, .d_store, .i_ren, .i_addr,
    .ram_load, .ram_wait,
    .d_load, .d_wait, .i_load, .i_wait,
    .ram_ren, .ram_wen, .ram_addr, .ram_store
  );

  ram_model ram_i (
    .CLK, .nRST,
    .ram_ren, .ram_wen, .ram_addr, .ram_store,
    .ram_load, .ram_wait
  );

endmodule

// ==== source/ram_model.sv ====
`timescale 1ns/1ps
`include "cache_consts.svh"

module ram_model
  import cpu_types_pkg::*;
  import mem_bus_pkg::*;
#(
  parameter int LATENCY = `RAM_LATENCY
) (
  input  logic  CLK,
  input  logic  nRST,
  input  logic  ram_ren,
  input  logic  ram_wen,
  input  word_t ram_addr,
  input  word_t ram_store,
  output word_t ram_load,
  output logic  ram_wait
);

  localparam int AW = $clog2(`RAM_WORDS);
  localparam int CNT_W = $clog2(LATENCY + 1);

  word_t mem [`RAM_WORDS];
  ram_state_t state;
  logic [CNT_W-1:0] busy_cnt;
  logic [AW-1:0] widx;
  logic req;

  assign req = ram_ren | ram_wen;
  assign widx = ram_addr[AW+1:2];

  // Busy for LATENCY cycles, done in the one after
  assign ram_wait = req && (state != RAM_DONE);
  assign ram_load = (state == RAM_DONE && ram_ren) ? mem[widx] : '0;

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      state <= RAM_IDLE;
      busy_cnt <= '0;
    end else begin
      case (state)
        RAM_IDLE: begin
          if (req) begin
            busy_cnt <= CNT_W'(1);
            state <= (LATENCY == 1) ? RAM_DONE : RAM_BUSY;
          end
        end
        RAM_BUSY: begin
          if (!req) begin
            state <= RAM_IDLE;
          end else if (busy_cnt == CNT_W'(LATENCY - 1)) begin
            state <= RAM_DONE;
          end else begin
            busy_cnt <= busy_cnt + 1'b1;
          end
        end
        default: state <= RAM_IDLE;
      endcase
    end
  end

  // Known pattern at reset, write lands in the done cycle
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      for (int i = 0; i < `RAM_WORDS; i++) begin
        mem[i] <= word_t'(i * 4) ^ `RAM_INIT_KEY;
      end
    end else if (state == RAM_DONE && ram_wen) begin
      mem[widx] <= ram_store;
    end
  end

endmodule
